/* hdl/soc_pkg.sv */
package soc_pkg;

    // --------------------------------------------------
    // bus widths
    // --------------------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // slave select from the address decoder
    typedef enum logic [1:0] {
        SLV_RAM,
        SLV_TIMER,
        SLV_GPIO,
        SLV_NONE
    } slave_e;

    // region codes in adr[31:28]
    localparam logic [3:0] REGION_RAM   = 4'h0;
    localparam logic [3:0] REGION_TIMER = 4'h1;
    localparam logic [3:0] REGION_GPIO  = 4'h2;

    // --------------------------------------------------
    // register word offsets, adr[3:2]
    // --------------------------------------------------
    localparam logic [1:0] TMR_CTRL  = 2'd0;
    localparam logic [1:0] TMR_VALUE = 2'd1;
    localparam logic [1:0] TMR_CMP   = 2'd2;

    // timer ctrl bits
    localparam int TMR_CTRL_EN   = 0;
    localparam int TMR_CTRL_IE   = 1;
    localparam int TMR_CTRL_PEND = 2;

    localparam logic [1:0] GPIO_DIR = 2'd0;
    localparam logic [1:0] GPIO_OUT = 2'd1;
    localparam logic [1:0] GPIO_IN  = 2'd2;

endpackage

/* hdl/wb_if.sv */
`timescale 1ns/1ns

// wishbone classic, one word per access
interface wb_if;
    import soc_pkg::*;

    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat_w;
    logic [DATA_W-1:0] dat_r;
    logic              ack;

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

/* hdl/bus_arbiter.sv */
`timescale 1ns/1ns

module bus_arbiter (
    input  logic clk,
    input  logic rst_n_i,
    wb_if.slave  m0_if,
    wb_if.slave  m1_if,
    wb_if.master bus_if
);

    logic busy_q;
    logic owner_q;
    logic grant_m1;

    // owner locked while busy and m0 first when idle
    assign grant_m1 = busy_q ? owner_q : (!m0_if.cyc && m1_if.cyc);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            owner_q <= 1'b0;
        end else if (!busy_q) begin
            if (m0_if.cyc || m1_if.cyc) begin
                busy_q  <= 1'b1;
                owner_q <= grant_m1;
            end
        end else if (!(owner_q ? m1_if.cyc : m0_if.cyc)) begin
            // bus frees up once the owner drops cyc
            busy_q <= 1'b0;
        end
    end

    // --------------------------------------------------
    // forward the granted master
    // --------------------------------------------------
    assign bus_if.cyc   = grant_m1 ? m1_if.cyc   : m0_if.cyc;
    assign bus_if.stb   = grant_m1 ? m1_if.stb   : m0_if.stb;
    assign bus_if.we    = grant_m1 ? m1_if.we    : m0_if.we;
    assign bus_if.adr   = grant_m1 ? m1_if.adr   : m0_if.adr;
    assign bus_if.dat_w = grant_m1 ? m1_if.dat_w : m0_if.dat_w;

    // the waiting master sees no ack and no data
    assign m0_if.ack   = bus_if.ack & ~grant_m1;
    assign m1_if.ack   = bus_if.ack & grant_m1;
    assign m0_if.dat_r = grant_m1 ? '0 : bus_if.dat_r;
    assign m1_if.dat_r = grant_m1 ? bus_if.dat_r : '0;

    // acks only land in a locked cycle at a master still holding cyc
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (m0_if.ack || m1_if.ack) |-> busy_q && (m1_if.ack ? m1_if.cyc : m0_if.cyc));

endmodule

/* hdl/bus_decoder.sv */
`timescale 1ns/1ns

module bus_decoder (
    input  logic clk,
    input  logic rst_n_i,
    wb_if.slave  m_if,
    wb_if.master ram_if,
    wb_if.master tmr_if,
    wb_if.master gpio_if
);
    import soc_pkg::*;

    slave_e sel;
    logic   none_ack_q;

    always_comb begin
        case (m_if.adr[ADDR_W-1:ADDR_W-4])
            REGION_RAM:   sel = SLV_RAM;
            REGION_TIMER: sel = SLV_TIMER;
            REGION_GPIO:  sel = SLV_GPIO;
            default:      sel = SLV_NONE;
        endcase
    end

    // --------------------------------------------------
    // strobes gated per slave
    // --------------------------------------------------
    assign ram_if.cyc    = m_if.cyc && (sel == SLV_RAM);
    assign ram_if.stb    = m_if.stb && (sel == SLV_RAM);
    assign ram_if.we     = m_if.we;
    assign ram_if.adr    = m_if.adr;
    assign ram_if.dat_w  = m_if.dat_w;

    assign tmr_if.cyc    = m_if.cyc && (sel == SLV_TIMER);
    assign tmr_if.stb    = m_if.stb && (sel == SLV_TIMER);
    assign tmr_if.we     = m_if.we;
    assign tmr_if.adr    = m_if.adr;
    assign tmr_if.dat_w  = m_if.dat_w;

    assign gpio_if.cyc   = m_if.cyc && (sel == SLV_GPIO);
    assign gpio_if.stb   = m_if.stb && (sel == SLV_GPIO);
    assign gpio_if.we    = m_if.we;
    assign gpio_if.adr   = m_if.adr;
    assign gpio_if.dat_w = m_if.dat_w;

    // own ack for unmapped regions so the master never hangs
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            none_ack_q <= 1'b0;
        end else begin
            none_ack_q <= m_if.cyc && m_if.stb && (sel == SLV_NONE) && !none_ack_q;
        end
    end

    always_comb begin
        case (sel)
            SLV_RAM: begin
                m_if.dat_r = ram_if.dat_r;
                m_if.ack   = ram_if.ack;
            end
            SLV_TIMER: begin
                m_if.dat_r = tmr_if.dat_r;
                m_if.ack   = tmr_if.ack;
            end
            SLV_GPIO: begin
                m_if.dat_r = gpio_if.dat_r;
                m_if.ack   = gpio_if.ack;
            end
            default: begin
                m_if.dat_r = '0;
                m_if.ack   = none_ack_q;
            end
        endcase
    end

    // one responder at a time on the return path
    assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({ram_if.ack, tmr_if.ack, gpio_if.ack, none_ack_q}));

endmodule

/* hdl/data_ram.sv */
`timescale 1ns/1ns

module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic clk,
    input  logic rst_n_i,
    wb_if.slave  bus_if
);
    import soc_pkg::*;

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [DATA_W-1:0] mem [0:RAM_WORDS-1];
    logic [DATA_W-1:0] rdata_q;
    logic [IDX_W-1:0]  idx;
    logic              ack_q;
    logic              access;

    // word address without the byte offset bits
    assign idx    = bus_if.adr[IDX_W+1:2];
    assign access = bus_if.cyc && bus_if.stb && !ack_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (bus_if.we) begin
                mem[idx] <= bus_if.dat_w;
            end else begin
                rdata_q <= mem[idx];
            end
        end
    end

    assign bus_if.ack   = ack_q;
    assign bus_if.dat_r = rdata_q;

    // master holds its strobe until it sees ack
    assert property (@(posedge clk) disable iff (!rst_n_i)
        bus_if.ack |-> bus_if.cyc && bus_if.stb);

endmodule

/* hdl/timer_unit.sv */
`timescale 1ns/1ns

module timer_unit (
    input  logic clk,
    input  logic rst_n_i,
    wb_if.slave  bus_if,
    output logic irq_o
);
    import soc_pkg::*;

    logic              en_q;
    logic              ie_q;
    logic              pend_q;
    logic [DATA_W-1:0] cnt_q;
    logic [DATA_W-1:0] cmp_q;
    logic [DATA_W-1:0] rdata_q;
    logic              ack_q;
    logic [1:0]        offs;
    logic              access;
    logic              wr_en;
    logic              wr_ctrl;
    logic              match;

    assign offs    = bus_if.adr[3:2];
    assign access  = bus_if.cyc && bus_if.stb && !ack_q;
    assign wr_en   = access && bus_if.we;
    assign wr_ctrl = wr_en && (offs == TMR_CTRL);
    assign match   = en_q && (cnt_q == cmp_q);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q  <= 1'b0;
            en_q   <= 1'b0;
            ie_q   <= 1'b0;
            pend_q <= 1'b0;
            cnt_q  <= '0;
            cmp_q  <= '0;
        end else begin
            ack_q <= access;
            // count up and wrap on compare
            if (match) begin
                cnt_q <= '0;
            end else if (en_q) begin
                cnt_q <= cnt_q + 1'b1;
            end
            // a match wins over a clear in the same cycle
            if (match) begin
                pend_q <= 1'b1;
            end else if (wr_ctrl && bus_if.dat_w[TMR_CTRL_PEND]) begin
                pend_q <= 1'b0;
            end
            if (wr_en) begin
                case (offs)
                    TMR_CTRL: begin
                        en_q <= bus_if.dat_w[TMR_CTRL_EN];
                        ie_q <= bus_if.dat_w[TMR_CTRL_IE];
                    end
                    TMR_VALUE: cnt_q <= bus_if.dat_w;
                    TMR_CMP:   cmp_q <= bus_if.dat_w;
                    default:   ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (offs)
                TMR_CTRL:  rdata_q <= {{(DATA_W-3){1'b0}}, pend_q, ie_q, en_q};
                TMR_VALUE: rdata_q <= cnt_q;
                TMR_CMP:   rdata_q <= cmp_q;
                default:   rdata_q <= '0;
            endcase
        end
    end

    assign bus_if.ack   = ack_q;
    assign bus_if.dat_r = rdata_q;
    assign irq_o        = pend_q & ie_q;

    // a register access stays strobed up to its ack
    assert property (@(posedge clk) disable iff (!rst_n_i)
        bus_if.ack |-> bus_if.cyc && bus_if.stb);

endmodule

/* hdl/gpio_port.sv */
`timescale 1ns/1ns

module gpio_port #(
    parameter int GPIO_W = 16
) (
    input  logic              clk,
    input  logic              rst_n_i,
    wb_if.slave               bus_if,
    input  logic [GPIO_W-1:0] pin_i,
    output logic [GPIO_W-1:0] pin_o,
    output logic [GPIO_W-1:0] oe_o
);
    import soc_pkg::*;

    logic [GPIO_W-1:0] dir_q;
    logic [GPIO_W-1:0] out_q;
    logic [GPIO_W-1:0] sync1_q;
    logic [GPIO_W-1:0] sync2_q;
    logic [DATA_W-1:0] rdata_q;
    logic              ack_q;
    logic [1:0]        offs;
    logic              access;

    assign offs   = bus_if.adr[3:2];
    assign access = bus_if.cyc && bus_if.stb && !ack_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q   <= 1'b0;
            dir_q   <= '0;
            out_q   <= '0;
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            ack_q   <= access;
            // two flop input sync
            sync1_q <= pin_i;
            sync2_q <= sync1_q;
            if (access && bus_if.we) begin
                if (offs == GPIO_DIR) dir_q <= bus_if.dat_w[GPIO_W-1:0];
                if (offs == GPIO_OUT) out_q <= bus_if.dat_w[GPIO_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (offs)
                GPIO_DIR: rdata_q <= DATA_W'(dir_q);
                GPIO_OUT: rdata_q <= DATA_W'(out_q);
                GPIO_IN:  rdata_q <= DATA_W'(sync2_q);
                default:  rdata_q <= '0;
            endcase
        end
    end

    assign bus_if.ack   = ack_q;
    assign bus_if.dat_r = rdata_q;
    assign oe_o         = dir_q;
    assign pin_o        = out_q;

endmodule

/* hdl/mini_soc.sv */
`timescale 1ns/1ns

module mini_soc #(
    parameter int RAM_WORDS = 256,
    parameter int GPIO_W    = 16
) (
    input  logic                        clk,
    input  logic                        rst_n_i,
    // core data port
    input  logic                        m0_cyc_i,
    input  logic                        m0_stb_i,
    input  logic                        m0_we_i,
    input  logic [soc_pkg::ADDR_W-1:0]  m0_adr_i,
    input  logic [soc_pkg::DATA_W-1:0]  m0_dat_i,
    output logic [soc_pkg::DATA_W-1:0]  m0_dat_o,
    output logic                        m0_ack_o,
    // debug port
    input  logic                        m1_cyc_i,
    input  logic                        m1_stb_i,
    input  logic                        m1_we_i,
    input  logic [soc_pkg::ADDR_W-1:0]  m1_adr_i,
    input  logic [soc_pkg::DATA_W-1:0]  m1_dat_i,
    output logic [soc_pkg::DATA_W-1:0]  m1_dat_o,
    output logic                        m1_ack_o,
    input  logic [GPIO_W-1:0]           gpio_in_i,
    output logic [GPIO_W-1:0]           gpio_out_o,
    output logic [GPIO_W-1:0]           gpio_oe_o,
    output logic                        timer_irq_o
);

    wb_if m0 ();
    wb_if m1 ();
    wb_if wb_m ();
    wb_if wb_ram ();
    wb_if wb_tmr ();
    wb_if wb_gpio ();

    // --------------------------------------------------
    // master ports into bus form
    // --------------------------------------------------
    assign m0.cyc   = m0_cyc_i;
    assign m0.stb   = m0_stb_i;
    assign m0.we    = m0_we_i;
    assign m0.adr   = m0_adr_i;
    assign m0.dat_w = m0_dat_i;
    assign m0_dat_o = m0.dat_r;
    assign m0_ack_o = m0.ack;

    assign m1.cyc   = m1_cyc_i;
    assign m1.stb   = m1_stb_i;
    assign m1.we    = m1_we_i;
    assign m1.adr   = m1_adr_i;
    assign m1.dat_w = m1_dat_i;
    assign m1_dat_o = m1.dat_r;
    assign m1_ack_o = m1.ack;

    bus_arbiter u_bus_arbiter (
        .clk        ( clk           ),
        .rst_n_i    ( rst_n_i       ),
        .m0_if      ( m0            ),
        .m1_if      ( m1            ),
        .bus_if     ( wb_m          )
    );

    bus_decoder u_bus_decoder (
        .clk        ( clk           ),
        .rst_n_i    ( rst_n_i       ),
        .m_if       ( wb_m          ),
        .ram_if     ( wb_ram        ),
        .tmr_if     ( wb_tmr        ),
        .gpio_if    ( wb_gpio       )
    );

    data_ram #(
        .RAM_WORDS  ( RAM_WORDS     )
    ) u_data_ram (
        .clk        ( clk           ),
        .rst_n_i    ( rst_n_i       ),
        .bus_if     ( wb_ram        )
    );

    timer_unit u_timer_unit (
        .clk        ( clk           ),
        .rst_n_i    ( rst_n_i       ),
        .bus_if     ( wb_tmr        ),
        .irq_o      ( timer_irq_o   )
    );

    // split pin, no tri-state at this level
    gpio_port #(
        .GPIO_W     ( GPIO_W        )
    ) u_gpio_port (
        .clk        ( clk           ),
        .rst_n_i    ( rst_n_i       ),
        .bus_if     ( wb_gpio       ),
        .pin_i      ( gpio_in_i     ),
        .pin_o      ( gpio_out_o    ),
        .oe_o       ( gpio_oe_o     )
    );

endmodule

/* tb/tb_mini_soc.sv */
`timescale 1ns/1ns

module tb_mini_soc;
    import soc_pkg::*;

    localparam int RAM_WORDS   = 256;
    localparam int GPIO_W      = 16;
    localparam int CLK_HALF    = 5;
    // clock edges from driving stb to sampling ack
    localparam int ACK_LAT     = 2;
    localparam int BUS_TIMEOUT = 20;
    localparam int TMR_MATCH   = 20;
    localparam int IRQ_WINDOW  = 30;
    // summed test length, doubled for the watchdog
    localparam int TEST_NS     = 10000;
    localparam int WATCHDOG_NS = 2 * TEST_NS;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              cyc_q  [2];
    logic              stb_q  [2];
    logic              we_q   [2];
    logic [ADDR_W-1:0] adr_q  [2];
    logic [DATA_W-1:0] wdat_q [2];
    wire  [DATA_W-1:0] rdat_w [2];
    wire               ack_w  [2];
    logic [GPIO_W-1:0] gpio_in;
    wire  [GPIO_W-1:0] gpio_out;
    wire  [GPIO_W-1:0] gpio_oe;
    wire               timer_irq;

    logic [DATA_W-1:0] ram_model [0:RAM_WORDS-1];
    integer            seed      = 32'h8ce9;
    int                val_errs  = 0;
    int                misc_errs = 0;

    mini_soc #(
        .RAM_WORDS   ( RAM_WORDS  ),
        .GPIO_W      ( GPIO_W     )
    ) i_dut (
        .clk         ( clk        ),
        .rst_n_i     ( rst_n      ),
        .m0_cyc_i    ( cyc_q[0]   ),
        .m0_stb_i    ( stb_q[0]   ),
        .m0_we_i     ( we_q[0]    ),
        .m0_adr_i    ( adr_q[0]   ),
        .m0_dat_i    ( wdat_q[0]  ),
        .m0_dat_o    ( rdat_w[0]  ),
        .m0_ack_o    ( ack_w[0]   ),
        .m1_cyc_i    ( cyc_q[1]   ),
        .m1_stb_i    ( stb_q[1]   ),
        .m1_we_i     ( we_q[1]    ),
        .m1_adr_i    ( adr_q[1]   ),
        .m1_dat_i    ( wdat_q[1]  ),
        .m1_dat_o    ( rdat_w[1]  ),
        .m1_ack_o    ( ack_w[1]   ),
        .gpio_in_i   ( gpio_in    ),
        .gpio_out_o  ( gpio_out   ),
        .gpio_oe_o   ( gpio_oe    ),
        .timer_irq_o ( timer_irq  )
    );

    always #CLK_HALF clk = ~clk;

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic chk_word(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            val_errs++;
        end
    endtask

    task automatic chk_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
            val_errs++;
        end
    endtask

    task automatic chk_gpio(input string name, input logic [GPIO_W-1:0] exp,
                            input logic [GPIO_W-1:0] act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            val_errs++;
        end
    endtask

    task automatic check_latency(input int m, input int lat);
        if (lat != ACK_LAT) begin
            $display("m%0d ack took %0d clock edges after stb, expected %0d", m, lat, ACK_LAT);
            misc_errs++;
        end
    endtask

    // --------------------------------------------------
    // bus tasks
    // --------------------------------------------------
    task automatic bus_cycle(input int m, input logic we, input logic [ADDR_W-1:0] adr,
                             input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat,
                             output int lat);
        int   n;
        logic got;
        n    = 0;
        got  = 1'b0;
        rdat = '0;
        @(posedge clk);
        cyc_q[m]  <= 1'b1;
        stb_q[m]  <= 1'b1;
        we_q[m]   <= we;
        adr_q[m]  <= adr;
        wdat_q[m] <= wdat;
        while (!got && n < BUS_TIMEOUT) begin
            @(posedge clk);
            n++;
            if (ack_w[m]) begin
                got  = 1'b1;
                rdat = rdat_w[m];
            end
        end
        cyc_q[m] <= 1'b0;
        stb_q[m] <= 1'b0;
        we_q[m]  <= 1'b0;
        lat = n;
        if (!got) begin
            $display("bus timeout: m%0d got no ack for address %h", m, adr);
            misc_errs++;
        end
    endtask

    task automatic bus_write(input int m, input logic [ADDR_W-1:0] adr,
                             input logic [DATA_W-1:0] wdat, output int lat);
        logic [DATA_W-1:0] unused;
        bus_cycle(m, 1'b1, adr, wdat, unused, lat);
    endtask

    task automatic bus_read(input int m, input logic [ADDR_W-1:0] adr,
                            output logic [DATA_W-1:0] rdat, output int lat);
        bus_cycle(m, 1'b0, adr, '0, rdat, lat);
    endtask

    // address map: region in the top nibble, word offset from bit 2
    function automatic logic [ADDR_W-1:0] ram_adr(input int idx);
        return {REGION_RAM, 28'(idx * 4)};
    endfunction

    function automatic logic [ADDR_W-1:0] reg_adr(input logic [3:0] region,
                                                  input logic [1:0] offs);
        return {region, 24'h0, offs, 2'b00};
    endfunction

    function automatic logic [DATA_W-1:0] ctrl_word(input logic en, input logic ie,
                                                    input logic pend);
        logic [DATA_W-1:0] w;
        w                = '0;
        w[TMR_CTRL_EN]   = en;
        w[TMR_CTRL_IE]   = ie;
        w[TMR_CTRL_PEND] = pend;
        return w;
    endfunction

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic test_reset();
        chk_bit("m0_ack_o", 1'b0, ack_w[0]);
        chk_bit("m1_ack_o", 1'b0, ack_w[1]);
        chk_bit("timer_irq_o", 1'b0, timer_irq);
        chk_gpio("gpio_oe_o", '0, gpio_oe);
        chk_gpio("gpio_out_o", '0, gpio_out);
    endtask

    task automatic test_ram();
        int                idx [16];
        logic [DATA_W-1:0] d;
        int                lat;
        for (int i = 0; i < 16; i++) begin
            idx[i] = $random(seed) & (RAM_WORDS - 1);
            d      = $random(seed);
            ram_model[idx[i]] = d;
            bus_write(0, ram_adr(idx[i]), d, lat);
            check_latency(0, lat);
        end
        // read back on the debug port
        for (int i = 0; i < 16; i++) begin
            bus_read(1, ram_adr(idx[i]), d, lat);
            check_latency(1, lat);
            chk_word("m1_dat_o", ram_model[idx[i]], d);
        end
    endtask

    task automatic test_arbitration();
        logic [DATA_W-1:0] wd;
        logic [DATA_W-1:0] rd;
        int                lat0;
        int                lat1;
        // known word for the contested read
        wd = $random(seed);
        ram_model[7] = wd;
        bus_write(0, ram_adr(7), wd, lat0);
        wd = $random(seed);
        fork
            bus_write(0, ram_adr(9), wd, lat0);
            bus_read(1, ram_adr(7), rd, lat1);
        join
        ram_model[9] = wd;
        check_latency(0, lat0);
        if (lat1 <= lat0) begin
            $display("m1 was acked before m0 released the bus");
            misc_errs++;
        end
        chk_word("m1_dat_o", ram_model[7], rd);
        bus_read(1, ram_adr(9), rd, lat1);
        chk_word("m1_dat_o", ram_model[9], rd);
    endtask

    task automatic test_unmapped();
        logic [DATA_W-1:0] d;
        logic [ADDR_W-1:0] bad_adr;
        int                lat;
        // same low bits as RAM word 16, region 0xF
        bad_adr = {4'hF, 28'(16 * 4)};
        d = $random(seed);
        ram_model[16] = d;
        bus_write(0, ram_adr(16), d, lat);
        bus_write(0, bad_adr, $random(seed), lat);
        check_latency(0, lat);
        bus_read(0, bad_adr, d, lat);
        chk_word("m0_dat_o", '0, d);
        bus_read(1, ram_adr(16), d, lat);
        chk_word("m1_dat_o", ram_model[16], d);
    endtask

    task automatic test_gpio();
        logic [DATA_W-1:0] dir;
        logic [DATA_W-1:0] outv;
        logic [DATA_W-1:0] rd;
        logic [GPIO_W-1:0] pins;
        int                lat;
        dir  = $random(seed);
        outv = $random(seed);
        bus_write(0, reg_adr(REGION_GPIO, GPIO_DIR), dir, lat);
        bus_write(0, reg_adr(REGION_GPIO, GPIO_OUT), outv, lat);
        chk_gpio("gpio_oe_o", dir[GPIO_W-1:0], gpio_oe);
        chk_gpio("gpio_out_o", outv[GPIO_W-1:0], gpio_out);
        pins = $random(seed);
        @(posedge clk);
        gpio_in <= pins;
        repeat (3) @(posedge clk);
        bus_read(0, reg_adr(REGION_GPIO, GPIO_IN), rd, lat);
        chk_word("m0_dat_o", DATA_W'(pins), rd);
    endtask

    task automatic test_timer();
        logic [DATA_W-1:0] rd;
        logic [ADDR_W-1:0] ctrl_adr;
        int                lat;
        int                n;
        logic              seen;
        ctrl_adr = reg_adr(REGION_TIMER, TMR_CTRL);
        bus_write(0, reg_adr(REGION_TIMER, TMR_CMP), DATA_W'(TMR_MATCH), lat);
        bus_write(0, ctrl_adr, ctrl_word(1'b1, 1'b1, 1'b0), lat);
        n = 0;
        while (!timer_irq && n < IRQ_WINDOW) begin
            @(posedge clk);
            n++;
        end
        if (!timer_irq) begin
            $display("timer_irq_o did not rise within %0d cycles", IRQ_WINDOW);
            misc_errs++;
        end
        bus_read(0, ctrl_adr, rd, lat);
        chk_word("m0_dat_o", ctrl_word(1'b1, 1'b1, 1'b1), rd);
        // stop the counter so no match lands on the clear
        bus_write(0, ctrl_adr, ctrl_word(1'b0, 1'b1, 1'b0), lat);
        bus_write(0, ctrl_adr, ctrl_word(1'b0, 1'b1, 1'b1), lat);
        chk_bit("timer_irq_o", 1'b0, timer_irq);
        // restart from zero, interrupt masked
        bus_write(0, reg_adr(REGION_TIMER, TMR_VALUE), '0, lat);
        bus_write(0, ctrl_adr, ctrl_word(1'b1, 1'b0, 1'b0), lat);
        seen = 1'b0;
        repeat (IRQ_WINDOW) begin
            @(posedge clk);
            if (timer_irq) seen = 1'b1;
        end
        chk_bit("timer_irq_o", 1'b0, seen);
        // pending set shows the match did happen
        bus_read(0, ctrl_adr, rd, lat);
        chk_word("m0_dat_o", ctrl_word(1'b1, 1'b0, 1'b1), rd);
    endtask

    // --------------------------------------------------
    // main sequence and watchdog
    // --------------------------------------------------
    initial begin
        for (int m = 0; m < 2; m++) begin
            cyc_q[m]  = 1'b0;
            stb_q[m]  = 1'b0;
            we_q[m]   = 1'b0;
            adr_q[m]  = '0;
            wdat_q[m] = '0;
        end
        gpio_in = '0;
        rst_n   = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        test_reset();
        test_ram();
        test_arbitration();
        test_unmapped();
        test_gpio();
        test_timer();
        $display("summary: %0d value errors, %0d other errors", val_errs, misc_errs);
        if (val_errs + misc_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, tests did not finish", $time);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* src.f */
hdl/soc_pkg.sv
hdl/wb_if.sv
hdl/bus_arbiter.sv
hdl/bus_decoder.sv
hdl/data_ram.sv
hdl/timer_unit.sv
hdl/gpio_port.sv
hdl/mini_soc.sv
tb/tb_mini_soc.sv

/* Makefile */
# Verilator build and run for the mini SoC bus subsystem

VERILATOR ?= verilator
TOP       ?= tb_mini_soc
RTL_TOP   ?= mini_soc
SEED      ?= 0
LOG       ?= sim.log
BUILD     ?= obj_dir
FLIST     ?= src.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -j 0 --top-module $(TOP) \
		-f $(FLIST) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)
